/* Bender.yml */
package:
  name: branch_unit

sources:
  - include_dirs:
      - hdl
    files:
      # packages before their users
      - hdl/isa_pkg.sv
      - hdl/bpred_pkg.sv
      - hdl/branch_decode.sv
      - hdl/fu_branch.sv
      - hdl/branch_predictor.sv
      - hdl/branch_unit_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_branch_unit.sv

/* hdl/bpred_params.svh */
`ifndef BPRED_PARAMS_SVH
`define BPRED_PARAMS_SVH

// data and PC width
`define XLEN 32

// predictor depth, as log2 of the entry count
`define BP_INDEX_BITS 4
`define BP_ENTRIES (1 << `BP_INDEX_BITS)

// PC bits left above the index and the 2-bit word offset
`define BP_TAG_BITS (`XLEN - `BP_INDEX_BITS - 2)

// low and high PC bit of the table index
`define BP_INDEX_LO 2
`define BP_INDEX_HI (`BP_INDEX_BITS + 1)

`endif

/* hdl/bpred_pkg.sv */
`default_nettype none

package bpred_pkg;

  // two-bit saturating direction counter
  // MSB set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } ctr_t;

  // state after reset
  parameter ctr_t CTR_INIT = WEAK_NT;

  // restart values when an entry is taken over by a new tag
  parameter ctr_t CTR_NEW_TAKEN     = WEAK_T;
  parameter ctr_t CTR_NEW_NOT_TAKEN = WEAK_NT;

endpackage

`default_nettype wire

/* hdl/branch_decode.sv */
`include "bpred_params.svh"

`default_nettype none

module branch_decode
  import isa_pkg::*;
(
  input  logic [31:0]       instr,
  output branch_type_t      branch_type,
  output logic              branch_gate_sel,
  output logic [`XLEN-1:0]  imm,
  output logic              illegal
);

  opcode_t opcode;
  funct3_t funct3;
  logic    is_branch;
  logic    bad_funct3;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = funct3_t'(instr[14:12]);

  assign is_branch  = (opcode == BRANCH);
  assign bad_funct3 = (instr[14:13] == 2'b01);  // 010, 011

  // funct3 bit 0 flips the base compare
  assign branch_gate_sel = instr[12];

  // B-type immediate: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
  assign imm = {{(`XLEN-12){instr[31]}},  // sign fill incl. imm[12]
                instr[7],                 // imm[11]
                instr[30:25],             // imm[10:5]
                instr[11:8],              // imm[4:1]
                1'b0};                    // halfword aligned

  always_comb begin
    branch_type = CMP_NONE;
    if (is_branch) begin
      case (funct3)
        BEQ, BNE:   branch_type = CMP_EQ;
        BLT, BGE:   branch_type = CMP_LT;
        BLTU, BGEU: branch_type = CMP_LTU;
        default:    branch_type = CMP_NONE;
      endcase
    end
  end

  assign illegal = ~is_branch | bad_funct3;

endmodule

`default_nettype wire

/* hdl/branch_predictor.sv */
`include "bpred_params.svh"

`default_nettype none

module branch_predictor
  import bpred_pkg::*;
(
  input  logic              CLK,
  input  logic              arst_n,
  input  logic [`XLEN-1:0]  fetch_pc,
  output logic              pred_taken,
  output logic [`XLEN-1:0]  pred_target,
  input  logic              update_btb,
  input  logic [`XLEN-1:0]  update_pc,
  input  logic [`XLEN-1:0]  branch_target,
  input  logic              branch_outcome
);

  logic                      valid_q  [`BP_ENTRIES];
  logic [`BP_TAG_BITS-1:0]   tag_q    [`BP_ENTRIES];
  logic [`XLEN-1:0]          target_q [`BP_ENTRIES];
  ctr_t                      ctr_q    [`BP_ENTRIES];

  logic [`BP_INDEX_BITS-1:0] fetch_idx;
  logic [`BP_TAG_BITS-1:0]   fetch_tag;
  logic                      fetch_hit;
  logic [`BP_INDEX_BITS-1:0] upd_idx;
  logic [`BP_TAG_BITS-1:0]   upd_tag;
  logic                      upd_hit;
  ctr_t                      ctr_next;

  // one saturating step toward the resolved direction
  function automatic ctr_t ctr_step(input ctr_t cur, input logic taken);
    ctr_t nxt;
    case (cur)
      STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
      WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
      STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
      default:   nxt = CTR_INIT;
    endcase
    return nxt;
  endfunction

  // lookup side
  assign fetch_idx = fetch_pc[`BP_INDEX_HI:`BP_INDEX_LO];
  assign fetch_tag = fetch_pc[`XLEN-1:`BP_INDEX_HI+1];
  assign fetch_hit = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);

  assign pred_taken  = fetch_hit & ctr_q[fetch_idx][1];  // counter MSB
  // falls through to the next word when not taken
  assign pred_target = pred_taken ? target_q[fetch_idx] : fetch_pc + `XLEN'd4;

  // update side
  assign upd_idx = update_pc[`BP_INDEX_HI:`BP_INDEX_LO];
  assign upd_tag = update_pc[`XLEN-1:`BP_INDEX_HI+1];
  assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

  always_comb begin
    if (upd_hit) begin
      ctr_next = ctr_step(ctr_q[upd_idx], branch_outcome);
    end else begin
      // new tag restarts the counter
      ctr_next = branch_outcome ? CTR_NEW_TAKEN : CTR_NEW_NOT_TAKEN;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
        ctr_q[i]   <= CTR_INIT;
      end
    end else if (update_btb) begin
      valid_q[upd_idx] <= 1'b1;
      ctr_q[upd_idx]   <= ctr_next;
    end
  end

  // tag and target of the updated entry
  always_ff @(posedge CLK) begin
    if (update_btb) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= branch_target;
    end
  end

endmodule

`default_nettype wire

/* hdl/branch_unit_top.sv */
`include "bpred_params.svh"

`default_nettype none

module branch_unit_top
  import isa_pkg::*;
(
  input  logic              CLK,
  input  logic              arst_n,
  // issue side
  input  logic              issue_valid,
  input  logic [`XLEN-1:0]  issue_pc,
  input  logic [31:0]       issue_instr,
  input  logic [`XLEN-1:0]  reg_a,
  input  logic [`XLEN-1:0]  reg_b,
  input  logic              predicted_outcome,
  // resolve side
  output logic              resolve_valid,
  output logic              branch_outcome,
  output logic              misprediction,
  output logic [`XLEN-1:0]  correct_pc,
  output logic              update_btb,
  output logic [`XLEN-1:0]  update_pc,
  output logic [`XLEN-1:0]  branch_target,
  output logic              illegal_branch,
  // fetch lookup
  input  logic [`XLEN-1:0]  fetch_pc,
  output logic              pred_taken,
  output logic [`XLEN-1:0]  pred_target
);

  branch_type_t     branch_type;
  logic             branch_gate_sel;
  logic [`XLEN-1:0] imm;
  logic             illegal;

  branch_decode u_decode (
    .instr           (issue_instr),
    .branch_type     (branch_type),
    .branch_gate_sel (branch_gate_sel),
    .imm             (imm),
    .illegal         (illegal)
  );

  fu_branch u_fu_branch (
    .CLK               (CLK),
    .arst_n            (arst_n),
    .branch            (issue_valid),
    .illegal           (illegal),
    .branch_type       (branch_type),
    .branch_gate_sel   (branch_gate_sel),
    .reg_a             (reg_a),
    .reg_b             (reg_b),
    .current_pc        (issue_pc),
    .imm               (imm),
    .predicted_outcome (predicted_outcome),
    .resolve_valid     (resolve_valid),
    .branch_outcome    (branch_outcome),
    .misprediction     (misprediction),
    .correct_pc        (correct_pc),
    .update_btb        (update_btb),
    .update_pc         (update_pc),
    .branch_target     (branch_target),
    .illegal_branch    (illegal_branch)
  );

  // trained from the registered resolve outputs
  branch_predictor u_predictor (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .fetch_pc       (fetch_pc),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .update_btb     (update_btb),
    .update_pc      (update_pc),
    .branch_target  (branch_target),
    .branch_outcome (branch_outcome)
  );

endmodule

`default_nettype wire

/* hdl/fu_branch.sv */
`include "bpred_params.svh"

`default_nettype none

module fu_branch
  import isa_pkg::*;
(
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              branch,
  input  logic              illegal,
  input  branch_type_t      branch_type,
  input  logic              branch_gate_sel,
  input  logic [`XLEN-1:0]  reg_a,
  input  logic [`XLEN-1:0]  reg_b,
  input  logic [`XLEN-1:0]  current_pc,
  input  logic [`XLEN-1:0]  imm,
  input  logic              predicted_outcome,
  output logic              resolve_valid,
  output logic              branch_outcome,
  output logic              misprediction,
  output logic [`XLEN-1:0]  correct_pc,
  output logic              update_btb,
  output logic [`XLEN-1:0]  update_pc,
  output logic [`XLEN-1:0]  branch_target,
  output logic              illegal_branch
);

  logic             zero;
  logic             actual_outcome;
  logic             mispredict_d;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] taken_target;
  logic [`XLEN-1:0] next_pc;

  // high when the base relation holds
  always_comb begin
    case (branch_type)
      CMP_EQ:  zero = (reg_a == reg_b);
      CMP_LT:  zero = ($signed(reg_a) < $signed(reg_b));
      CMP_LTU: zero = (reg_a < reg_b);
      default: zero = 1'b0;
    endcase
  end

  assign pc_plus4     = current_pc + `XLEN'd4;
  assign taken_target = current_pc + imm;

  // illegal words never count as taken
  assign actual_outcome = ~illegal & (zero ^ branch_gate_sel);
  assign mispredict_d   = ~illegal & (actual_outcome != predicted_outcome);
  assign next_pc        = actual_outcome ? taken_target : pc_plus4;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      resolve_valid  <= 1'b0;
      branch_outcome <= 1'b0;
      misprediction  <= 1'b0;
      update_btb     <= 1'b0;
      illegal_branch <= 1'b0;
    end else begin
      resolve_valid  <= branch;
      branch_outcome <= branch & actual_outcome;
      misprediction  <= branch & mispredict_d;
      update_btb     <= branch & ~illegal;  // only real branches train
      illegal_branch <= branch & illegal;
    end
  end

  // payload, qualified by resolve_valid / update_btb
  always_ff @(posedge CLK) begin
    correct_pc    <= next_pc;
    update_pc     <= current_pc;
    branch_target <= taken_target;
  end

endmodule

`default_nettype wire

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  // conditional branch funct3, instr[14:12]
  // 010 and 011 are unused encodings
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } funct3_t;

  // base comparison done by the branch unit
  // funct3 bit 0 inverts it for BNE, BGE and BGEU
  typedef enum logic [1:0] {
    CMP_EQ   = 2'd0,   // BEQ, BNE
    CMP_LT   = 2'd1,   // BLT, BGE
    CMP_LTU  = 2'd2,   // BLTU, BGEU
    CMP_NONE = 2'd3    // not a valid branch
  } branch_type_t;

endpackage

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/bpred_pkg.sv
hdl/branch_decode.sv
hdl/fu_branch.sv
hdl/branch_predictor.sv
hdl/branch_unit_top.sv
testbench/tb_branch_unit.sv

/* testbench/branch_tests.txt */
# R pc instr reg_a reg_b pred | exp outcome mispredict correct_pc illegal (hex)
# L fetch_pc | exp pred_taken pred_target (hex)
# all six conditions, issued back to back
R 00001000 00208863 00000005 00000005 1 1 0 00001010 0
R 00001004 00208863 00000005 00000006 0 0 0 00001008 0
R 00001008 00209863 00000007 00000007 0 0 0 0000100c 0
R 0000100c 00209863 00000007 00000008 1 1 0 0000101c 0
R 00001010 0020c863 ffffffff 00000001 1 1 0 00001020 0
R 00001014 0020e863 ffffffff 00000001 0 0 0 00001018 0
R 00001018 0020d863 ffffffff 00000001 0 0 0 0000101c 0
R 0000101c 0020f863 ffffffff 00000001 1 1 0 0000102c 0
R 00001020 0020d863 00000003 00000003 1 1 0 00001030 0
R 00001024 0020e863 00000001 ffffffff 1 1 0 00001034 0
# mispredictions both ways, negative offsets
R 00002040 fe208ce3 00000009 00000009 0 1 1 00002038 0
R 00002044 fe209ce3 00000009 00000009 1 0 1 00002048 0
R 00002048 0020c863 00000001 ffffffff 1 0 1 0000204c 0
R 0000204c fe20fce3 ffffffff 00000001 0 1 1 00002044 0
R 00003000 fe20cce3 80000000 00000000 1 1 0 00002ff8 0
# illegal words, no training
R 00004030 00208833 00000001 00000001 1 0 0 00004034 1
R 00004034 0020a863 00000001 00000002 0 0 0 00004038 1
L 00004030 0 00004034
L 00004034 0 00004038
# counter training on one entry
L 00005038 0 0000503c
R 00005038 00208863 00000001 00000001 0 1 1 00005048 0
L 00005038 1 00005048
R 00005038 00208863 00000001 00000001 1 1 0 00005048 0
R 00005038 00208863 00000001 00000002 1 0 1 0000503c 0
L 00005038 1 00005048
R 00005038 00208863 00000001 00000002 1 0 1 0000503c 0
L 00005038 0 0000503c
# aliasing on index 14, entry strong taken first
R 00005038 00208863 00000001 00000001 0 1 1 00005048 0
R 00005038 00208863 00000001 00000001 1 1 0 00005048 0
L 00005038 1 00005048
L 00006038 0 0000603c
R 00006038 00209863 00000004 00000004 0 0 0 0000603c 0
L 00006038 0 0000603c
L 00005038 0 0000503c
# same pc trained on consecutive cycles
R 00007010 00208863 0000000a 0000000a 0 1 1 00007020 0
R 00007010 00208863 0000000a 0000000a 1 1 0 00007020 0
R 00007010 00208863 0000000a 0000000b 1 0 1 00007014 0
L 00007010 1 00007020

/* testbench/tb_branch_unit.sv */
`include "bpred_params.svh"

`default_nettype none

module tb_branch_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    MAX_TESTS = 128;
  localparam string TEST_FILE = "testbench/branch_tests.txt";

  logic             CLK;
  logic             arst_n;
  logic             issue_valid;
  logic [`XLEN-1:0] issue_pc;
  logic [31:0]      issue_instr;
  logic [`XLEN-1:0] reg_a;
  logic [`XLEN-1:0] reg_b;
  logic             predicted_outcome;
  logic             resolve_valid;
  logic             branch_outcome;
  logic             misprediction;
  logic [`XLEN-1:0] correct_pc;
  logic             update_btb;
  logic [`XLEN-1:0] update_pc;
  logic [`XLEN-1:0] branch_target;
  logic             illegal_branch;
  logic [`XLEN-1:0] fetch_pc;
  logic             pred_taken;
  logic [`XLEN-1:0] pred_target;

  byte         kind_tab  [MAX_TESTS];     // R resolve, L lookup
  logic [31:0] field_tab [MAX_TESTS][9];  // columns as in the test file
  int          num_tests   = 0;
  int          pend_idx   [$];            // branches in flight, issue order
  int          pend_cycle [$];            // sample where each must resolve
  int          cycle_count = 0;
  int          cycle_limit = 50;
  int          pass_count  = 0;
  int          fail_count  = 0;

  branch_unit_top UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic report_mismatch(input int idx, input string sig,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("error: test %0d %s expected 0x%08h got 0x%08h", idx + 1, sig, expected, actual);
  endtask

  task automatic finish_test(input int idx, input int errs);
    if (errs == 0) begin
      pass_count++;
      $display("test %0d %c pc 0x%08h ok", idx + 1, kind_tab[idx], field_tab[idx][0]);
    end else begin
      fail_count++;
      $display("test %0d %c pc 0x%08h had %0d mismatches", idx + 1, kind_tab[idx],
               field_tab[idx][0], errs);
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    string       kind;
    logic [31:0] v0, v1, v2, v3, v4, v5, v6, v7, v8;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test file %s", TEST_FILE);
      fail_count++;
    end else begin
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        line = "";
        if ($fgets(line, fd) == 0) continue;
        n = $sscanf(line, "%s", kind);
        if (n < 1 || kind[0] == "#") continue;  // blank or comment line
        kind_tab[num_tests] = kind[0];
        if (kind == "R") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind,
                      v0, v1, v2, v3, v4, v5, v6, v7, v8);
        end else if (kind == "L") begin
          n = $sscanf(line, "%s %h %h %h", kind, v0, v1, v2);
          n = (n == 4) ? 10 : n;
        end else begin
          n = 0;
        end
        if (n != 10) begin
          $display("test file line for test %0d is malformed: %s", num_tests + 1, line);
          fail_count++;
        end else begin
          field_tab[num_tests][0] = v0;
          field_tab[num_tests][1] = v1;
          field_tab[num_tests][2] = v2;
          field_tab[num_tests][3] = v3;
          field_tab[num_tests][4] = v4;
          field_tab[num_tests][5] = v5;
          field_tab[num_tests][6] = v6;
          field_tab[num_tests][7] = v7;
          field_tab[num_tests][8] = v8;
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // one branch per rising edge, captured by the DUT on the next one
  task automatic issue_branch(input int idx);
    @(posedge CLK);
    issue_valid       <= 1'b1;
    issue_pc          <= field_tab[idx][0];
    issue_instr       <= field_tab[idx][1];
    reg_a             <= field_tab[idx][2];
    reg_b             <= field_tab[idx][3];
    predicted_outcome <= field_tab[idx][4][0];
    pend_idx.push_back(idx);
    pend_cycle.push_back(cycle_count + 2);  // capture edge, then result edge
  endtask

  task automatic run_lookup(input int idx);
    int errs;
    errs = 0;
    @(posedge CLK);
    issue_valid <= 1'b0;
    fetch_pc    <= field_tab[idx][0];
    @(posedge CLK);  // last resolve writes the tables here
    @(negedge CLK);
    if (pred_taken !== field_tab[idx][1][0]) begin
      report_mismatch(idx, "pred_taken", field_tab[idx][1], pred_taken);
      errs++;
    end
    if (pred_target !== field_tab[idx][2]) begin
      report_mismatch(idx, "pred_target", field_tab[idx][2], pred_target);
      errs++;
    end
    finish_test(idx, errs);
  endtask

  task automatic check_resolve();
    int idx;
    int due;
    int errs;
    errs = 0;
    if (pend_idx.size() == 0) begin
      $display("resolve_valid went high with no branch in flight");
      fail_count++;
    end else begin
      idx = pend_idx.pop_front();
      due = pend_cycle.pop_front();
      if (cycle_count != due) begin
        $display("test %0d resolved %0d cycles away from its slot", idx + 1, cycle_count - due);
        errs++;
      end
      if (branch_outcome !== field_tab[idx][5][0]) begin
        report_mismatch(idx, "branch_outcome", field_tab[idx][5], branch_outcome);
        errs++;
      end
      if (misprediction !== field_tab[idx][6][0]) begin
        report_mismatch(idx, "misprediction", field_tab[idx][6], misprediction);
        errs++;
      end
      if (correct_pc !== field_tab[idx][7]) begin
        report_mismatch(idx, "correct_pc", field_tab[idx][7], correct_pc);
        errs++;
      end
      // a taken branch redirects to its target
      if (field_tab[idx][5][0] && branch_target !== field_tab[idx][7]) begin
        report_mismatch(idx, "branch_target", field_tab[idx][7], branch_target);
        errs++;
      end
      if (illegal_branch !== field_tab[idx][8][0]) begin
        report_mismatch(idx, "illegal_branch", field_tab[idx][8], illegal_branch);
        errs++;
      end
      if (update_btb !== !field_tab[idx][8][0]) begin  // legal branches train
        report_mismatch(idx, "update_btb", !field_tab[idx][8][0], update_btb);
        errs++;
      end
      if (update_pc !== field_tab[idx][0]) begin
        report_mismatch(idx, "update_pc", field_tab[idx][0], update_pc);
        errs++;
      end
      finish_test(idx, errs);
    end
  endtask

  // results are sampled mid-cycle
  always @(negedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end else if (resolve_valid) begin
      check_resolve();
    end
  end

  initial begin
    arst_n            = 1'b0;
    issue_valid       = 1'b0;
    issue_pc          = '0;
    issue_instr       = '0;
    reg_a             = '0;
    reg_b             = '0;
    predicted_outcome = 1'b0;
    fetch_pc          = '0;
    load_tests();
    cycle_limit = 4 * num_tests + 50;
    repeat (8) @(posedge CLK);
    arst_n <= 1'b1;
    for (int i = 0; i < num_tests; i++) begin
      if (kind_tab[i] == "R") issue_branch(i);
      else run_lookup(i);
    end
    @(posedge CLK);
    issue_valid <= 1'b0;
    while (pend_idx.size() != 0) @(negedge CLK);
    @(negedge CLK);  // catch a late extra resolve
    $display("%0d tests run, %0d passed, %0d failed", num_tests, pass_count, fail_count);
    if (fail_count == 0 && num_tests > 0 && pass_count == num_tests) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
